/* filelist.f */
+incdir+common
+incdir+dv
common/axil_pkg.sv
common/mem_pkg.sv
bram_ctrl/axil_req_decode.sv
bram_ctrl/bram_port_exec.sv
bram_ctrl/axil_resp_gen.sv
bram_ctrl/axil_bram_ctrl.sv
hw/dp_ram.sv
hw/mem_subsys_top.sv
dv/tb_mem_subsys.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_mem_subsys
FILELIST = filelist.f
SIM      = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with $(TOOL)"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(SIM)

clean:
	rm -rf obj_dir

/* dv/tb_mem_tasks.svh */
`ifndef TB_MEM_TASKS_SVH
`define TB_MEM_TASKS_SVH

typedef struct packed {
	logic		wr;
	axil_r_t	r;
} exp_t;

logic	[31:0]	model [`MEM_WORDS];
exp_t			exp_q [2][$];

function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
		input logic [3:0] strb);
	merge_bytes = old;
	for (int i = 0; i < 4; i++)
		if (strb[i])
			merge_bytes[8*i +: 8] = data[8*i +: 8];
endfunction

task automatic check_b(input string name, input axil_b_t exp, input axil_b_t act);
	if (act !== exp) begin
		$display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
		stop_fail();
	end
endtask

task automatic check_r(input string name, input axil_r_t exp, input axil_r_t act);
	if (act !== exp) begin
		$display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
		stop_fail();
	end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
		stop_fail();
	end
endtask

task automatic check_count(input string name, input int exp, input int act);
	if (act != exp) begin
		$display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
		stop_fail();
	end
endtask

// called just after a falling edge; returns at the falling edge after the handshake
task automatic wait_accept(input int p, input int kind, input string what);
	int n;
	n = 0;
	#1;
	while (!((kind == 0 && aw_ready[p] && w_ready[p]) || (kind == 1 && aw_ready[p])
			|| (kind == 2 && w_ready[p]) || (kind == 3 && ar_ready[p]))) begin
		n++;
		if (n > WAIT_LIMIT)
			abort_run({what, " was never accepted"});
		else begin
			@(negedge clk);
			#1;
		end
	end
	@(negedge clk);
endtask

task automatic wait_b(input int p, output axil_b_t resp, output int lat);
	lat = 1;
	#1;
	while (!b_valid[p]) begin
		lat++;
		if (lat > WAIT_LIMIT)
			abort_run("write response never arrived");
		else begin
			@(negedge clk);
			#1;
		end
	end
	resp = b[p];
endtask

task automatic axil_write(input int p, input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output axil_b_t resp, output int lat);
	@(negedge clk);
	aw[p].addr = addr;
	w[p].data = data;
	w[p].strb = strb;
	aw_valid[p] = 1'b1;
	w_valid[p] = 1'b1;
	wait_accept(p, 0, "write");
	aw_valid[p] = 1'b0;
	w_valid[p] = 1'b0;
	wait_b(p, resp, lat);
endtask

task automatic axil_read(input int p, input logic [31:0] addr, output axil_r_t resp,
		output int lat);
	@(negedge clk);
	ar[p].addr = addr;
	ar_valid[p] = 1'b1;
	wait_accept(p, 3, "read");
	ar_valid[p] = 1'b0;
	lat = 1;
	#1;
	while (!r_valid[p]) begin
		lat++;
		if (lat > WAIT_LIMIT)
			abort_run("read response never arrived");
		else begin
			@(negedge clk);
			#1;
		end
	end
	resp = r[p];
endtask

task automatic write_ok(input int p, input int idx, input logic [31:0] data,
		input logic [3:0] strb);
	axil_b_t	got;
	axil_b_t	exp;
	int			lat;
	exp.resp = AXIL_OKAY;
	axil_write(p, 32'(idx * 4), data, strb, got, lat);
	check_b("b", exp, got);
	model[idx] = merge_bytes(model[idx], data, strb);
endtask

task automatic read_check(input int p, input int idx);
	axil_r_t	got;
	axil_r_t	exp;
	int			lat;
	exp.data = model[idx];
	exp.resp = AXIL_OKAY;
	axil_read(p, 32'(idx * 4), got, lat);
	check_r("r", exp, got);
endtask

task automatic test_reset_and_basic();
	axil_b_t	bg;
	axil_b_t	be;
	axil_r_t	rg;
	axil_r_t	re;
	int			lat;
	#1;
	for (int p = 0; p < 2; p++) begin
		check_flag("b_valid", 1'b0, b_valid[p]);
		check_flag("r_valid", 1'b0, r_valid[p]);
		check_flag("aw_ready", 1'b1, aw_ready[p]);
		check_flag("w_ready", 1'b1, w_ready[p]);
		check_flag("ar_ready", 1'b1, ar_ready[p]);
	end
	be.resp = AXIL_OKAY;
	axil_write(0, 32'h0000_0010, 32'hdead_beef, 4'hf, bg, lat);
	check_b("b", be, bg);
	check_count("write latency", 3, lat);
	model[4] = 32'hdead_beef;
	re.data = 32'hdead_beef;
	re.resp = AXIL_OKAY;
	axil_read(0, 32'h0000_0010, rg, lat);
	check_r("r", re, rg);
	check_count("read latency", 3, lat);
endtask

task automatic test_byte_strobes();
	logic	[31:0]	d;
	write_ok(0, 8, 32'h0000_0000, 4'hf);
	for (int s = 0; s < 16; s++) begin
		take_bits(0, 32, d);
		write_ok(0, 8, d, 4'(s));
		read_check(0, 8);
	end
endtask

task automatic test_cross_port();
	write_ok(1, 100, 32'h1234_5678, 4'hf);
	read_check(0, 100);
	write_ok(0, 200, 32'h8765_4321, 4'hf);
	read_check(1, 200);
endtask

task automatic test_out_of_range();
	axil_b_t	bg;
	axil_b_t	be;
	axil_r_t	rg;
	axil_r_t	re;
	int			lat;
	write_ok(1, 37, 32'hcafe_f00d, 4'hf);
	be.resp = AXIL_SLVERR;
	axil_write(1, 32'(`MEM_BYTES + 37 * 4), 32'h5555_aaaa, 4'hf, bg, lat);
	check_b("b", be, bg);
	re.data = '0;
	re.resp = AXIL_SLVERR;
	axil_read(1, 32'(`MEM_BYTES + 37 * 4), rg, lat);
	check_r("r", re, rg);
	axil_read(0, 32'h0001_0000 + 32'(37 * 4), rg, lat);
	check_r("r", re, rg);
	read_check(0, 37);
endtask

task automatic write_split(input int p, input int idx, input logic [31:0] data,
		input logic aw_first);
	axil_b_t	got;
	axil_b_t	exp;
	int			lat;
	@(negedge clk);
	aw[p].addr = 32'(idx * 4);
	w[p].data = data;
	w[p].strb = 4'hf;
	if (aw_first) begin
		aw_valid[p] = 1'b1;
		wait_accept(p, 1, "write address");
		aw_valid[p] = 1'b0;
		w_valid[p] = 1'b1;
		wait_accept(p, 2, "write data");
	end else begin
		w_valid[p] = 1'b1;
		wait_accept(p, 2, "write data");
		w_valid[p] = 1'b0;
		aw_valid[p] = 1'b1;
		wait_accept(p, 1, "write address");
	end
	aw_valid[p] = 1'b0;
	w_valid[p] = 1'b0;
	wait_b(p, got, lat);
	exp.resp = AXIL_OKAY;
	check_b("b", exp, got);
	model[idx] = data;
endtask

task automatic test_split_write();
	write_split(0, 300, 32'h0f0f_1111, 1'b1);
	read_check(0, 300);
	write_split(1, 301, 32'hf0f0_2222, 1'b0);
	read_check(1, 301);
endtask

task automatic stream_issue(input int p, input int base, input int n);
	logic	[31:0]	k;
	logic	[31:0]	ix;
	logic	[31:0]	d;
	logic	[31:0]	s;
	int				idx;
	exp_t			e;
	@(negedge clk);
	for (int i = 0; i < n; i++) begin
		take_bits(p, 1, k);
		take_bits(p, 4, ix);
		take_bits(p, 32, d);
		take_bits(p, 4, s);
		idx = base + int'(ix[3:0]);
		if (k[0]) begin
			aw[p].addr = 32'(idx * 4);
			w[p].data = d;
			w[p].strb = s[3:0];
			aw_valid[p] = 1'b1;
			w_valid[p] = 1'b1;
			wait_accept(p, 0, "stream write");
			model[idx] = merge_bytes(model[idx], d, s[3:0]);
			e.wr = 1'b1;
			e.r.data = '0;
		end else begin
			ar[p].addr = 32'(idx * 4);
			ar_valid[p] = 1'b1;
			wait_accept(p, 3, "stream read");
			e.wr = 1'b0;
			e.r.data = model[idx];
		end
		e.r.resp = AXIL_OKAY;
		exp_q[p].push_back(e);
		aw_valid[p] = 1'b0;
		w_valid[p] = 1'b0;
		ar_valid[p] = 1'b0;
	end
endtask

task automatic stream_collect(input int p, input int n);
	logic	[31:0]	x;
	axil_b_t		eb;
	exp_t			e;
	int				got;
	int				cyc;
	got = 0;
	cyc = 0;
	while (got < n) begin
		@(negedge clk);
		take_bits(p + 2, 1, x);
		b_ready[p] = x[0];
		take_bits(p + 2, 1, x);
		r_ready[p] = x[0];
		#1;
		cyc++;
		if (cyc > TEST_CYCLES)
			abort_run("stream responses stopped arriving");
		else if ((b_valid[p] && b_ready[p]) || (r_valid[p] && r_ready[p])) begin
			if (exp_q[p].size() == 0)
				abort_run("response arrived with no request outstanding");
			else begin
				e = exp_q[p].pop_front();
				check_flag("b_valid", e.wr, b_valid[p]);
				if (e.wr) begin
					eb.resp = e.r.resp;
					check_b("b", eb, b[p]);
				end else
					check_r("r", e.r, r[p]);
				got++;
			end
		end
	end
	@(negedge clk);
	b_ready[p] = 1'b1;
	r_ready[p] = 1'b1;
endtask

task automatic test_backpressure();
	for (int i = 0; i < 16; i++) begin
		write_ok(0, 64 + i, 32'(i * 32'h0101_0101), 4'hf);
		write_ok(1, 576 + i, ~32'(i * 32'h0101_0101), 4'hf);
	end
	fork
		stream_issue(0, 64, 40);
		stream_collect(0, 40);
		stream_issue(1, 576, 40);
		stream_collect(1, 40);
	join
	// no extra response may follow the stream
	for (int c = 0; c < 8; c++) begin
		@(negedge clk);
		#1;
		for (int p = 0; p < 2; p++) begin
			check_flag("b_valid", 1'b0, b_valid[p]);
			check_flag("r_valid", 1'b0, r_valid[p]);
		end
	end
endtask

`endif

/* dv/tb_mem_subsys.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_consts.svh"

module tb_mem_subsys
	import axil_pkg::*;
;

	localparam int CLK_NS		= 40;
	localparam int NUM_TESTS	= 6;
	// longest test is the back-pressure stream
	localparam int TEST_CYCLES	= 3000;
	localparam int WATCHDOG_NS	= (NUM_TESTS * TEST_CYCLES + 200) * CLK_NS;
	localparam int WAIT_LIMIT	= 64;
	localparam logic [31:0] LFSR_SEED = 32'hf895_74a8;

	logic			clk;
	logic			rst;

	// index 0 is imem, index 1 is dmem
	axil_aw_t		aw [2];
	logic	[1:0]	aw_valid;
	wire	[1:0]	aw_ready;
	axil_w_t		w [2];
	logic	[1:0]	w_valid;
	wire	[1:0]	w_ready;
	axil_b_t		b [2];
	wire	[1:0]	b_valid;
	logic	[1:0]	b_ready;
	axil_ar_t		ar [2];
	logic	[1:0]	ar_valid;
	wire	[1:0]	ar_ready;
	axil_r_t		r [2];
	wire	[1:0]	r_valid;
	logic	[1:0]	r_ready;

	logic	[31:0]	lfsr_st [4];

	mem_subsys_top u_dut (
		.clk(clk),
		.rst(rst),
		.imem_aw(aw[0]),
		.imem_aw_valid(aw_valid[0]),
		.imem_aw_ready(aw_ready[0]),
		.imem_w(w[0]),
		.imem_w_valid(w_valid[0]),
		.imem_w_ready(w_ready[0]),
		.imem_b(b[0]),
		.imem_b_valid(b_valid[0]),
		.imem_b_ready(b_ready[0]),
		.imem_ar(ar[0]),
		.imem_ar_valid(ar_valid[0]),
		.imem_ar_ready(ar_ready[0]),
		.imem_r(r[0]),
		.imem_r_valid(r_valid[0]),
		.imem_r_ready(r_ready[0]),
		.dmem_aw(aw[1]),
		.dmem_aw_valid(aw_valid[1]),
		.dmem_aw_ready(aw_ready[1]),
		.dmem_w(w[1]),
		.dmem_w_valid(w_valid[1]),
		.dmem_w_ready(w_ready[1]),
		.dmem_b(b[1]),
		.dmem_b_valid(b_valid[1]),
		.dmem_b_ready(b_ready[1]),
		.dmem_ar(ar[1]),
		.dmem_ar_valid(ar_valid[1]),
		.dmem_ar_ready(ar_ready[1]),
		.dmem_r(r[1]),
		.dmem_r_valid(r_valid[1]),
		.dmem_r_ready(r_ready[1])
	);

	always #(CLK_NS / 2) clk = ~clk;

	task automatic stop_fail();
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic abort_run(input string msg);
		$display("error at %0t: %s", $time, msg);
		stop_fail();
	endtask

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int k, input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_st[k] = lfsr_next(lfsr_st[k]);
			v = {v[30:0], lfsr_st[k][0]};
		end
	endtask

	`include "tb_mem_tasks.svh"

	initial begin
		#(WATCHDOG_NS);
		abort_run("watchdog expired, the run did not finish in time");
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		aw_valid = '0;
		w_valid = '0;
		ar_valid = '0;
		b_ready = '1;
		r_ready = '1;
		for (int p = 0; p < 2; p++) begin
			aw[p] = '0;
			w[p] = '0;
			ar[p] = '0;
		end
		// separate streams so the ports do not share random values
		for (int k = 0; k < 4; k++) begin
			lfsr_st[k] = LFSR_SEED;
			for (int i = 0; i < 37 * k; i++)
				lfsr_st[k] = lfsr_next(lfsr_st[k]);
		end
		repeat (16) @(negedge clk);
		rst = 1'b0;
		repeat (2) @(negedge clk);
		test_reset_and_basic();
		test_byte_strobes();
		test_cross_port();
		test_out_of_range();
		test_split_write();
		test_backpressure();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/mem_subsys_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_consts.svh"

module mem_subsys_top
	import axil_pkg::*;
	import mem_pkg::*;
(
	input	logic		clk,
	input	logic		rst,

	// imem port
	input	axil_aw_t	imem_aw,
	input	logic		imem_aw_valid,
	output	logic		imem_aw_ready,
	input	axil_w_t	imem_w,
	input	logic		imem_w_valid,
	output	logic		imem_w_ready,
	output	axil_b_t	imem_b,
	output	logic		imem_b_valid,
	input	logic		imem_b_ready,
	input	axil_ar_t	imem_ar,
	input	logic		imem_ar_valid,
	output	logic		imem_ar_ready,
	output	axil_r_t	imem_r,
	output	logic		imem_r_valid,
	input	logic		imem_r_ready,

	// dmem port
	input	axil_aw_t	dmem_aw,
	input	logic		dmem_aw_valid,
	output	logic		dmem_aw_ready,
	input	axil_w_t	dmem_w,
	input	logic		dmem_w_valid,
	output	logic		dmem_w_ready,
	output	axil_b_t	dmem_b,
	output	logic		dmem_b_valid,
	input	logic		dmem_b_ready,
	input	axil_ar_t	dmem_ar,
	input	logic		dmem_ar_valid,
	output	logic		dmem_ar_ready,
	output	axil_r_t	dmem_r,
	output	logic		dmem_r_valid,
	input	logic		dmem_r_ready
);

	mem_port_t					ram_a;
	mem_port_t					ram_b;
	logic	[`MEM_DATA_W-1:0]	rdata_a;
	logic	[`MEM_DATA_W-1:0]	rdata_b;

	axil_bram_ctrl u_imem_ctrl (
		.clk(clk),
		.rst(rst),
		.aw(imem_aw),
		.aw_valid(imem_aw_valid),
		.aw_ready(imem_aw_ready),
		.w(imem_w),
		.w_valid(imem_w_valid),
		.w_ready(imem_w_ready),
		.b(imem_b),
		.b_valid(imem_b_valid),
		.b_ready(imem_b_ready),
		.ar(imem_ar),
		.ar_valid(imem_ar_valid),
		.ar_ready(imem_ar_ready),
		.r(imem_r),
		.r_valid(imem_r_valid),
		.r_ready(imem_r_ready),
		.ram(ram_a),
		.ram_rdata(rdata_a)
	);

	axil_bram_ctrl u_dmem_ctrl (
		.clk(clk),
		.rst(rst),
		.aw(dmem_aw),
		.aw_valid(dmem_aw_valid),
		.aw_ready(dmem_aw_ready),
		.w(dmem_w),
		.w_valid(dmem_w_valid),
		.w_ready(dmem_w_ready),
		.b(dmem_b),
		.b_valid(dmem_b_valid),
		.b_ready(dmem_b_ready),
		.ar(dmem_ar),
		.ar_valid(dmem_ar_valid),
		.ar_ready(dmem_ar_ready),
		.r(dmem_r),
		.r_valid(dmem_r_valid),
		.r_ready(dmem_r_ready),
		.ram(ram_b),
		.ram_rdata(rdata_b)
	);

	dp_ram u_ram (
		.clk(clk),
		.port_a(ram_a),
		.rdata_a(rdata_a),
		.port_b(ram_b),
		.rdata_b(rdata_b)
	);

endmodule

`default_nettype wire

/* hw/dp_ram.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_consts.svh"

module dp_ram
	import mem_pkg::*;
(
	input	logic						clk,

	input	mem_port_t					port_a,
	output	logic	[`MEM_DATA_W-1:0]	rdata_a,

	input	mem_port_t					port_b,
	output	logic	[`MEM_DATA_W-1:0]	rdata_b
);

	logic	[`MEM_DATA_W-1:0]	mem [`MEM_WORDS];

	// port b is applied last, so it wins a same-byte collision
	always_ff @(posedge clk) begin
		for (int i = 0; i < `MEM_STRB_W; i++) begin
			if (port_a.en && port_a.we[i])
				mem[port_a.idx][8*i +: 8] <= port_a.wdata[8*i +: 8];
			if (port_b.en && port_b.we[i])
				mem[port_b.idx][8*i +: 8] <= port_b.wdata[8*i +: 8];
		end
		// read before write
		if (port_a.en)
			rdata_a <= mem[port_a.idx];
		if (port_b.en)
			rdata_b <= mem[port_b.idx];
	end

endmodule

`default_nettype wire

/* bram_ctrl/axil_bram_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_consts.svh"

module axil_bram_ctrl
	import axil_pkg::*;
	import mem_pkg::*;
(
	input	logic						clk,
	input	logic						rst,

	input	axil_aw_t					aw,
	input	logic						aw_valid,
	output	logic						aw_ready,
	input	axil_w_t					w,
	input	logic						w_valid,
	output	logic						w_ready,
	output	axil_b_t					b,
	output	logic						b_valid,
	input	logic						b_ready,
	input	axil_ar_t					ar,
	input	logic						ar_valid,
	output	logic						ar_ready,
	output	axil_r_t					r,
	output	logic						r_valid,
	input	logic						r_ready,

	output	mem_port_t					ram,
	input	logic	[`MEM_DATA_W-1:0]	ram_rdata
);

	mem_op_t	op;
	logic		op_valid;
	logic		op_ready;
	mem_op_t	res;
	logic		res_valid;
	logic		res_ready;

	axil_req_decode u_decode (
		.clk(clk),
		.rst(rst),
		.aw(aw),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.w(w),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.ar(ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.op(op),
		.op_valid(op_valid),
		.op_ready(op_ready)
	);

	bram_port_exec u_exec (
		.clk(clk),
		.rst(rst),
		.op(op),
		.op_valid(op_valid),
		.op_ready(op_ready),
		.ram(ram),
		.res(res),
		.res_valid(res_valid),
		.res_ready(res_ready)
	);

	axil_resp_gen u_resp (
		.clk(clk),
		.rst(rst),
		.res(res),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.ram_rdata(ram_rdata),
		.b(b),
		.b_valid(b_valid),
		.b_ready(b_ready),
		.r(r),
		.r_valid(r_valid),
		.r_ready(r_ready)
	);

endmodule

`default_nettype wire

/* bram_ctrl/axil_resp_gen.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_consts.svh"

module axil_resp_gen
	import axil_pkg::*;
	import mem_pkg::*;
(
	input	logic						clk,
	input	logic						rst,

	input	mem_op_t					res,
	input	logic						res_valid,
	output	logic						res_ready,
	input	logic	[`MEM_DATA_W-1:0]	ram_rdata,

	output	axil_b_t					b,
	output	logic						b_valid,
	input	logic						b_ready,
	output	axil_r_t					r,
	output	logic						r_valid,
	input	logic						r_ready
);

	logic						hold_valid;
	logic						hold_wr;
	axil_resp_e					hold_resp;
	logic	[`MEM_DATA_W-1:0]	hold_data;
	logic						take;

	assign b_valid		= hold_valid & hold_wr;
	assign r_valid		= hold_valid & ~hold_wr;
	// single entry keeps b and r in request order
	assign res_ready	= ~hold_valid | (b_valid & b_ready) | (r_valid & r_ready);
	assign take			= res_valid & res_ready;

	assign b.resp	= hold_resp;
	assign r.resp	= hold_resp;
	assign r.data	= hold_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			hold_valid <= 1'b0;
		end else begin
			if (take)
				hold_valid <= 1'b1;
			else if (res_ready)
				hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			hold_wr		<= res.wr;
			hold_resp	<= res.err ? AXIL_SLVERR : AXIL_OKAY;
			hold_data	<= res.err ? '0 : ram_rdata;
		end
	end

endmodule

`default_nettype wire

/* bram_ctrl/bram_port_exec.sv */
`timescale 1ns/100ps
`default_nettype none

module bram_port_exec
	import mem_pkg::*;
(
	input	logic		clk,
	input	logic		rst,

	input	mem_op_t	op,
	input	logic		op_valid,
	output	logic		op_ready,

	output	mem_port_t	ram,

	output	mem_op_t	res,
	output	logic		res_valid,
	input	logic		res_ready
);

	logic		take;

	assign op_ready	= ~res_valid | res_ready;
	assign take		= op_valid & op_ready;

	// ram is only touched on the accepting cycle, so a stalled read keeps its word
	always_comb begin
		ram.en		= take & ~op.err;
		ram.we		= (take && !op.err && op.wr) ? op.strb : '0;
		ram.idx		= op.idx;
		ram.wdata	= op.wdata;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
		end else begin
			if (take)
				res_valid <= 1'b1;
			else if (res_ready)
				res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			res <= op;
	end

endmodule

`default_nettype wire

/* bram_ctrl/axil_req_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_consts.svh"

module axil_req_decode
	import axil_pkg::*;
	import mem_pkg::*;
(
	input	logic		clk,
	input	logic		rst,

	input	axil_aw_t	aw,
	input	logic		aw_valid,
	output	logic		aw_ready,
	input	axil_w_t	w,
	input	logic		w_valid,
	output	logic		w_ready,
	input	axil_ar_t	ar,
	input	logic		ar_valid,
	output	logic		ar_ready,

	output	mem_op_t	op,
	output	logic		op_valid,
	input	logic		op_ready
);

	logic		run;
	logic		free;
	logic		last_wr;
	logic		aw_held;
	logic		w_held;
	axil_aw_t	aw_q;
	axil_w_t	w_q;
	axil_aw_t	cur_aw;
	axil_w_t	cur_w;
	logic		wr_req;
	logic		grant_wr;
	logic		grant_rd;
	mem_op_t	next_op;

	function automatic logic addr_err(input logic [`MEM_ADDR_W-1:0] a);
		addr_err = (a[`MEM_ADDR_W-1:16] != '0) || (a[15:0] >= 16'(`MEM_BYTES));
	endfunction

	// a write may be formed from a held half and a live half
	assign cur_aw	= aw_held ? aw_q : aw;
	assign cur_w	= w_held ? w_q : w;
	assign wr_req	= (aw_held | aw_valid) & (w_held | w_valid);

	assign free		= run & (~op_valid | op_ready);
	// alternate when both are pending, write first after reset
	assign grant_wr	= free & wr_req & (~ar_valid | ~last_wr);
	assign grant_rd	= free & ar_valid & (~wr_req | last_wr);

	assign aw_ready	= free & ~aw_held;
	assign w_ready	= free & ~w_held;
	assign ar_ready	= free & (~wr_req | last_wr);

	always_comb begin
		next_op.wr		= grant_wr;
		next_op.err		= grant_wr ? addr_err(cur_aw.addr) : addr_err(ar.addr);
		next_op.idx		= grant_wr ? cur_aw.addr[`MEM_WORD_AW+1:2] : ar.addr[`MEM_WORD_AW+1:2];
		next_op.wdata	= grant_wr ? cur_w.data : '0;
		next_op.strb	= grant_wr ? cur_w.strb : '0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			run			<= 1'b0;
			op_valid	<= 1'b0;
			last_wr		<= 1'b0;
			aw_held		<= 1'b0;
			w_held		<= 1'b0;
		end else begin
			run <= 1'b1;
			if (grant_wr || grant_rd)
				op_valid <= 1'b1;
			else if (op_ready)
				op_valid <= 1'b0;
			if (grant_wr)
				last_wr <= 1'b1;
			else if (grant_rd)
				last_wr <= 1'b0;
			// park a half that arrived without its partner or lost arbitration
			if (grant_wr)
				aw_held <= 1'b0;
			else if (aw_valid && aw_ready)
				aw_held <= 1'b1;
			if (grant_wr)
				w_held <= 1'b0;
			else if (w_valid && w_ready)
				w_held <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (aw_valid && aw_ready)
			aw_q <= aw;
		if (w_valid && w_ready)
			w_q <= w;
		if (grant_wr || grant_rd)
			op <= next_op;
	end

endmodule

`default_nettype wire

/* common/mem_pkg.sv */
`default_nettype none

`include "mem_consts.svh"

package mem_pkg;

	// one decoded request, passed down the controller pipeline
	typedef struct packed {
		logic							wr;
		logic							err;
		logic	[`MEM_WORD_AW-1:0]		idx;
		logic	[`MEM_DATA_W-1:0]		wdata;
		logic	[`MEM_STRB_W-1:0]		strb;
	} mem_op_t;

	// one ram port access
	typedef struct packed {
		logic							en;
		logic	[`MEM_STRB_W-1:0]		we;
		logic	[`MEM_WORD_AW-1:0]		idx;
		logic	[`MEM_DATA_W-1:0]		wdata;
	} mem_port_t;

endpackage

`default_nettype wire

/* common/axil_pkg.sv */
`default_nettype none

`include "mem_consts.svh"

package axil_pkg;

	typedef enum logic [1:0] {
		AXIL_OKAY	= 2'b00,
		AXIL_SLVERR	= 2'b10
	} axil_resp_e;

	// write address channel
	typedef struct packed {
		logic	[`MEM_ADDR_W-1:0]	addr;
	} axil_aw_t;

	// write data channel
	typedef struct packed {
		logic	[`MEM_DATA_W-1:0]	data;
		logic	[`MEM_STRB_W-1:0]	strb;
	} axil_w_t;

	// write response channel
	typedef struct packed {
		axil_resp_e					resp;
	} axil_b_t;

	// read address channel
	typedef struct packed {
		logic	[`MEM_ADDR_W-1:0]	addr;
	} axil_ar_t;

	// read data channel
	typedef struct packed {
		logic	[`MEM_DATA_W-1:0]	data;
		axil_resp_e					resp;
	} axil_r_t;

endpackage

`default_nettype wire

/* common/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// word and byte address widths
`define MEM_DATA_W	32
`define MEM_ADDR_W	32
`define MEM_STRB_W	(`MEM_DATA_W / 8)

// ram depth in words
`define MEM_WORDS	1024
`define MEM_WORD_AW	10

// first byte address beyond the ram
`define MEM_BYTES	(`MEM_WORDS * `MEM_STRB_W)

`endif
